/* build.f */
verilog/mipi_rx_pkg.sv
verilog/mipi_rx_lane_sync.sv
verilog/mipi_rx_lane_recv.sv
verilog/mipi_rx_async_fifo.sv
verilog/mipi_rx_width_conv.sv
verilog/mipi_rx_lane.sv
sim/tb_mipi_rx_lane.sv

/* sim/tb_mipi_rx_lane.sv */
// --------------------------------------------------------------------------
// testbench for the CSI-2 receive lane merger
// sends seeded random bursts with per-lane sync skew on the byte clock,
// applies random tready on aclk and compares every output transfer
// against a byte-level model of the packed AXI4-Stream words
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_mipi_rx_lane;

    localparam int LANES          = 2;
    localparam int TDATA_SIZE     = 2;
    localparam int FIFO_PTR_WIDTH = 5;
    localparam int BW             = mipi_rx_pkg::BYTE_WIDTH;
    localparam int T_WIDTH        = 8 << TDATA_SIZE;
    localparam int T_BYTES        = 1 << TDATA_SIZE;
    localparam int NUM_BURSTS     = 40;
    localparam int MAX_WORDS      = 12;
    localparam int TIMEOUT        = 2000;
    localparam logic [7:0] SYNC_BYTE = 8'hb8;

    logic                   rst_n;
    logic                   rxbyteclkhs;
    logic [LANES*BW-1:0]    rxdatahs;
    logic [LANES-1:0]       rxvalidhs;
    logic [LANES-1:0]       rxactivehs;
    logic [LANES-1:0]       rxsynchs;
    logic                   aclk;
    logic [T_WIDTH-1:0]     tdata;
    logic                   tuser;
    logic                   tlast;
    logic                   tvalid;
    logic                   tready;

    integer                 seed;
    int                     errors;
    int                     transfers;
    int                     tlast_count;
    logic [BW-1:0]          payload [MAX_WORDS][LANES];
    logic [T_WIDTH-1:0]     exp_data [$];
    logic                   exp_user [$];
    logic                   exp_last [$];

    logic                   stalled;
    logic [T_WIDTH-1:0]     held_data;
    logic                   held_user;
    logic                   held_last;

    always #20 rxbyteclkhs = ~rxbyteclkhs;

    // same rate as the byte clock, shifted by 13 ns
    always begin
        #13;
        forever #20 aclk = ~aclk;
    end

    mipi_rx_lane #(
        .LANES          (LANES),
        .TDATA_SIZE     (TDATA_SIZE),
        .FIFO_PTR_WIDTH (FIFO_PTR_WIDTH)
    ) mipi_rx_lane_inst (
        .rst_n          (rst_n),
        .rxbyteclkhs    (rxbyteclkhs),
        .rxdatahs       (rxdatahs),
        .rxvalidhs      (rxvalidhs),
        .rxactivehs     (rxactivehs),
        .rxsynchs       (rxsynchs),
        .aclk           (aclk),
        .tdata          (tdata),
        .tuser          (tuser),
        .tlast          (tlast),
        .tvalid         (tvalid),
        .tready         (tready)
    );

    // --------------------------------------------------------------------------
    // reference model with lane 0 as the low byte of each lane word
    // --------------------------------------------------------------------------
    task automatic queue_expected(input int n_words);
        int n_bytes;
        int n_out;
        int w;
        int b;
        int idx;
        logic [T_WIDTH-1:0] word;
        n_bytes = n_words * LANES;
        n_out = (n_bytes + T_BYTES - 1) / T_BYTES;
        for (w = 0; w < n_out; w++) begin
            word = '0;
            for (b = 0; b < T_BYTES; b++) begin
                idx = w * T_BYTES + b;
                if (idx < n_bytes) begin
                    word[b*8 +: 8] = payload[idx / LANES][idx % LANES];
                end
            end
            exp_data.push_back(word);
            exp_user.push_back(w == 0);
            exp_last.push_back(w == n_out - 1);
        end
    endtask

    // one HS burst in which each lane starts after its own sync delay
    task automatic send_burst(input int n_words);
        int delay [LANES];
        int c;
        int j;
        int k;
        logic [LANES*BW-1:0] data_v;
        logic [LANES-1:0]    valid_v;
        logic [LANES-1:0]    sync_v;
        for (j = 0; j < LANES; j++) begin
            delay[j] = $unsigned($random(seed)) % (mipi_rx_pkg::MAX_SKEW + 1);
        end
        for (k = 0; k < n_words; k++) begin
            for (j = 0; j < LANES; j++) begin
                payload[k][j] = $random(seed);
            end
        end
        queue_expected(n_words);
        for (c = 0; c < n_words + 8; c++) begin
            data_v  = '0;
            valid_v = '0;
            sync_v  = '0;
            for (j = 0; j < LANES; j++) begin
                k = c - 1 - delay[j];
                if (k == 0) begin
                    sync_v[j] = 1'b1;
                    data_v[j*BW +: BW] = SYNC_BYTE;
                end else if (k >= 1 && k <= n_words) begin
                    valid_v[j] = 1'b1;
                    data_v[j*BW +: BW] = payload[k-1][j];
                end
            end
            @(posedge rxbyteclkhs);
            rxdatahs   <= data_v;
            rxvalidhs  <= valid_v;
            rxsynchs   <= sync_v;
            rxactivehs <= '1;
        end
        @(posedge rxbyteclkhs);
        rxdatahs   <= '0;
        rxvalidhs  <= '0;
        rxsynchs   <= '0;
        rxactivehs <= '0;
    endtask

    task automatic check_transfer();
        logic [T_WIDTH-1:0] e_data;
        logic               e_user;
        logic               e_last;
        transfers++;
        if (tlast) begin
            tlast_count++;
        end
        if (exp_data.size() == 0) begin
            $display("error at %0t: output transfer seen with no word left in the model",
                     $time);
            errors++;
        end else begin
            e_data = exp_data.pop_front();
            e_user = exp_user.pop_front();
            e_last = exp_last.pop_front();
            if (tdata !== e_data) begin
                $display("error at %0t: tdata expected %h got %h", $time, e_data, tdata);
                errors++;
            end
            if (tuser !== e_user) begin
                $display("error at %0t: tuser expected %b got %b", $time, e_user, tuser);
                errors++;
            end
            if (tlast !== e_last) begin
                $display("error at %0t: tlast expected %b got %b", $time, e_last, tlast);
                errors++;
            end
        end
    endtask

    // output monitor and random tready
    always @(posedge aclk) begin
        if (stalled) begin
            if (tvalid !== 1'b1) begin
                $display("error at %0t: tvalid expected 1 got %b", $time, tvalid);
                errors++;
            end
            if (tdata !== held_data) begin
                $display("error at %0t: tdata expected %h got %h", $time, held_data, tdata);
                errors++;
            end
            if (tuser !== held_user) begin
                $display("error at %0t: tuser expected %b got %b", $time, held_user, tuser);
                errors++;
            end
            if (tlast !== held_last) begin
                $display("error at %0t: tlast expected %b got %b", $time, held_last, tlast);
                errors++;
            end
        end
        if (tvalid === 1'b1 && tready === 1'b1) begin
            check_transfer();
        end
        stalled   = (tvalid === 1'b1) && (tready !== 1'b1);
        held_data = tdata;
        held_user = tuser;
        held_last = tlast;
        tready <= $random(seed);
    end

    initial begin
        int i;
        int n_words;
        int gap;
        int waited;
        seed        = 32'h368;
        errors      = 0;
        transfers   = 0;
        tlast_count = 0;
        stalled     = 1'b0;
        rst_n       = 1'b0;
        rxbyteclkhs = 1'b0;
        aclk        = 1'b0;
        rxdatahs    = '0;
        rxvalidhs   = '0;
        rxactivehs  = '0;
        rxsynchs    = '0;
        tready      = 1'b0;

        repeat (2) @(posedge rxbyteclkhs);
        rst_n <= 1'b1;

        // idle output before the first burst
        repeat (20) begin
            @(posedge rxbyteclkhs);
            if (tvalid !== 1'b0) begin
                $display("error at %0t: tvalid expected 0 got %b", $time, tvalid);
                errors++;
            end
        end

        for (i = 0; i < NUM_BURSTS; i++) begin
            // first burst is odd so a padded word is always seen
            if (i == 0) begin
                n_words = 3;
            end else begin
                n_words = $unsigned($random(seed)) % MAX_WORDS + 1;
            end
            send_burst(n_words);
            gap = 10 + $unsigned($random(seed)) % 8;
            repeat (gap) @(posedge rxbyteclkhs);
        end

        waited = 0;
        while (exp_data.size() != 0 && waited < TIMEOUT) begin
            @(posedge aclk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            $display("timeout, %0d expected output words never arrived", exp_data.size());
            errors++;
        end

        // quiet period so a late extra transfer is still caught
        repeat (50) @(posedge aclk);
        if (tlast_count != NUM_BURSTS) begin
            $display("error at %0t: tlast count expected %0d got %0d",
                     $time, NUM_BURSTS, tlast_count);
            errors++;
        end

        $display("errors: %0d  transfers: %0d  packets: %0d", errors, transfers, tlast_count);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mipi_rx_async_fifo.sv */
// --------------------------------------------------------------------------
// dual-clock FIFO from the byte clock into aclk
// register array with Gray pointers and a fall-through read register;
// the write side has no back-pressure and a write into a full FIFO is lost
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mipi_rx_async_fifo #(
    parameter int WIDTH     = 18,
    parameter int PTR_WIDTH = 5
) (
    input  logic                wr_rst_n,
    input  logic                rxbyteclkhs,
    input  logic [WIDTH-1:0]    wr_data,
    input  logic                wr_en,
    output logic                wr_full,

    input  logic                rd_rst_n,
    input  logic                aclk,
    output logic [WIDTH-1:0]    rd_data,
    output logic                rd_valid,
    input  logic                rd_ready
);

    localparam int DEPTH = 1 << PTR_WIDTH;

    logic [WIDTH-1:0]   mem [DEPTH];

    logic [PTR_WIDTH:0] wr_bin;
    logic [PTR_WIDTH:0] wr_gray;
    logic [PTR_WIDTH:0] wr_bin_next;
    logic [PTR_WIDTH:0] rd_gray_s1;
    logic [PTR_WIDTH:0] rd_gray_s2;

    logic [PTR_WIDTH:0] rd_bin;
    logic [PTR_WIDTH:0] rd_gray;
    logic [PTR_WIDTH:0] rd_bin_next;
    logic [PTR_WIDTH:0] wr_gray_s1;
    logic [PTR_WIDTH:0] wr_gray_s2;

    logic               empty;
    logic               load;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    assign wr_bin_next = wr_bin + 1'b1;
    // full when the pointers differ only in the two top Gray bits
    assign wr_full = (wr_gray == {~rd_gray_s2[PTR_WIDTH:PTR_WIDTH-1],
                                  rd_gray_s2[PTR_WIDTH-2:0]});

    always_ff @(posedge rxbyteclkhs or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (wr_en && !wr_full) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end
    end

    always_ff @(posedge rxbyteclkhs) begin
        if (wr_en && !wr_full) begin
            mem[wr_bin[PTR_WIDTH-1:0]] <= wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    assign empty       = (rd_gray == wr_gray_s2);
    assign load        = !empty && (!rd_valid || rd_ready);
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge aclk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            rd_valid   <= 1'b0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (load) begin
                rd_bin   <= rd_bin_next;
                rd_gray  <= rd_bin_next ^ (rd_bin_next >> 1);
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            rd_data <= mem[rd_bin[PTR_WIDTH-1:0]];
        end
    end

    // overflow report for the byte side that has no ready
    assert property (@(posedge rxbyteclkhs) disable iff (!wr_rst_n)
        !(wr_en && wr_full))
        else $error("async fifo overflow, word dropped");

endmodule

`default_nettype wire

/* verilog/mipi_rx_lane.sv */
// --------------------------------------------------------------------------
// CSI-2 D-PHY receive lane merger, top level
// byte-clock lanes in, AXI4-Stream out on aclk with tuser on the first
// word and tlast on the last word of each burst
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mipi_rx_lane #(
    parameter int LANES          = 2,
    parameter int TDATA_SIZE     = 2,
    parameter int FIFO_PTR_WIDTH = 5
) (
    input  logic                                       rst_n,
    input  logic                                       rxbyteclkhs,
    input  logic [LANES*mipi_rx_pkg::BYTE_WIDTH-1:0]   rxdatahs,
    input  logic [LANES-1:0]                           rxvalidhs,
    input  logic [LANES-1:0]                           rxactivehs,
    input  logic [LANES-1:0]                           rxsynchs,
    input  logic                                       aclk,
    output logic [(8 << TDATA_SIZE)-1:0]               tdata,
    output logic                                       tuser,
    output logic                                       tlast,
    output logic                                       tvalid,
    input  logic                                       tready
);

    localparam int DW = LANES * mipi_rx_pkg::BYTE_WIDTH;

    if (TDATA_SIZE < mipi_rx_pkg::lane_size(LANES)) begin : g_size_chk
        $error("TDATA_SIZE below lane size, downsizing unsupported");
    end

    // reset synchronizers with async assert and sync release
    logic [1:0] byte_rst_q;
    logic [1:0] axi_rst_q;

    always_ff @(posedge rxbyteclkhs or negedge rst_n) begin
        if (!rst_n) begin
            byte_rst_q <= '0;
        end else begin
            byte_rst_q <= {byte_rst_q[0], 1'b1};
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            axi_rst_q <= '0;
        end else begin
            axi_rst_q <= {axi_rst_q[0], 1'b1};
        end
    end

    logic [DW-1:0]  aligned_data;
    logic           aligned_valid;
    logic           aligned_active;
    logic           aligned_sync;
    logic [DW-1:0]  recv_data;
    logic           recv_first;
    logic           recv_last;
    logic           recv_valid;
    logic [DW-1:0]  fifo_data;
    logic           fifo_first;
    logic           fifo_last;
    logic           fifo_valid;
    logic           fifo_ready;

    mipi_rx_lane_sync #(
        .LANES          (LANES)
    ) i_mipi_rx_lane_sync (
        .rst_n          (byte_rst_q[1]),
        .rxbyteclkhs    (rxbyteclkhs),
        .rxdatahs       (rxdatahs),
        .rxvalidhs      (rxvalidhs),
        .rxactivehs     (rxactivehs),
        .rxsynchs       (rxsynchs),
        .aligned_data   (aligned_data),
        .aligned_valid  (aligned_valid),
        .aligned_active (aligned_active),
        .aligned_sync   (aligned_sync)
    );

    mipi_rx_lane_recv #(
        .LANES          (LANES)
    ) i_mipi_rx_lane_recv (
        .rst_n          (byte_rst_q[1]),
        .rxbyteclkhs    (rxbyteclkhs),
        .aligned_data   (aligned_data),
        .aligned_valid  (aligned_valid),
        .aligned_active (aligned_active),
        .aligned_sync   (aligned_sync),
        .recv_data      (recv_data),
        .recv_first     (recv_first),
        .recv_last      (recv_last),
        .recv_valid     (recv_valid)
    );

    mipi_rx_async_fifo #(
        .WIDTH          (mipi_rx_pkg::FLAG_WIDTH + DW),
        .PTR_WIDTH      (FIFO_PTR_WIDTH)
    ) i_mipi_rx_async_fifo (
        .wr_rst_n       (byte_rst_q[1]),
        .rxbyteclkhs    (rxbyteclkhs),
        .wr_data        ({recv_first, recv_last, recv_data}),
        .wr_en          (recv_valid),
        .wr_full        (),
        .rd_rst_n       (axi_rst_q[1]),
        .aclk           (aclk),
        .rd_data        ({fifo_first, fifo_last, fifo_data}),
        .rd_valid       (fifo_valid),
        .rd_ready       (fifo_ready)
    );

    mipi_rx_width_conv #(
        .LANES          (LANES),
        .TDATA_SIZE     (TDATA_SIZE)
    ) i_mipi_rx_width_conv (
        .rst_n          (axi_rst_q[1]),
        .aclk           (aclk),
        .s_data         (fifo_data),
        .s_first        (fifo_first),
        .s_last         (fifo_last),
        .s_valid        (fifo_valid),
        .s_ready        (fifo_ready),
        .tdata          (tdata),
        .tuser          (tuser),
        .tlast          (tlast),
        .tvalid         (tvalid),
        .tready         (tready)
    );

endmodule

`default_nettype wire

/* verilog/mipi_rx_lane_recv.sv */
// --------------------------------------------------------------------------
// packet framing on aligned lane words
// one word is held back so the final word of a burst can carry last
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mipi_rx_lane_recv #(
    parameter int LANES = 2
) (
    input  logic                                       rst_n,
    input  logic                                       rxbyteclkhs,
    input  logic [LANES*mipi_rx_pkg::BYTE_WIDTH-1:0]   aligned_data,
    input  logic                                       aligned_valid,
    input  logic                                       aligned_active,
    input  logic                                       aligned_sync,
    output logic [LANES*mipi_rx_pkg::BYTE_WIDTH-1:0]   recv_data,
    output logic                                       recv_first,
    output logic                                       recv_last,
    output logic                                       recv_valid
);

    logic [LANES*mipi_rx_pkg::BYTE_WIDTH-1:0] hold_data;
    logic   in_pkt;
    logic   hold_valid;
    logic   hold_first;
    logic   take;
    logic   emit;

    // payload only between the sync word and the fall of active
    assign take = in_pkt && aligned_active && aligned_valid && !aligned_sync;
    assign emit = hold_valid && ((in_pkt && !aligned_active) || take);

    always_ff @(posedge rxbyteclkhs or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt     <= 1'b0;
            hold_valid <= 1'b0;
            hold_first <= 1'b0;
            recv_valid <= 1'b0;
            recv_first <= 1'b0;
            recv_last  <= 1'b0;
        end else begin
            recv_valid <= emit;
            recv_first <= emit && hold_first;
            recv_last  <= emit && !aligned_active;
            if (aligned_sync) begin
                in_pkt     <= 1'b1;
                hold_valid <= 1'b0;
                hold_first <= 1'b1;
            end else if (in_pkt && !aligned_active) begin
                in_pkt     <= 1'b0;
                hold_valid <= 1'b0;
            end else if (take) begin
                hold_valid <= 1'b1;
                if (hold_valid) begin
                    hold_first <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge rxbyteclkhs) begin
        if (take) begin
            hold_data <= aligned_data;
        end
        if (emit) begin
            recv_data <= hold_data;
        end
    end

    // a new sync must not discard a held payload word
    assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
        aligned_sync |-> !hold_valid)
        else $error("held word lost to a new sync");

endmodule

`default_nettype wire

/* verilog/mipi_rx_lane_sync.sv */
// --------------------------------------------------------------------------
// lane deskew for the D-PHY byte stream
// each lane fills its own small elastic buffer from its sync byte on; once
// every lane holds data, all buffers are read in lockstep
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mipi_rx_lane_sync #(
    parameter int LANES = 2
) (
    input  logic                                       rst_n,
    input  logic                                       rxbyteclkhs,
    input  logic [LANES*mipi_rx_pkg::BYTE_WIDTH-1:0]   rxdatahs,
    input  logic [LANES-1:0]                           rxvalidhs,
    input  logic [LANES-1:0]                           rxactivehs,
    input  logic [LANES-1:0]                           rxsynchs,
    output logic [LANES*mipi_rx_pkg::BYTE_WIDTH-1:0]   aligned_data,
    output logic                                       aligned_valid,
    output logic                                       aligned_active,
    output logic                                       aligned_sync
);

    localparam int BW = mipi_rx_pkg::BYTE_WIDTH;
    localparam int PW = $clog2(mipi_rx_pkg::SKEW_DEPTH);

    logic [BW-1:0]              lane_buf [LANES][mipi_rx_pkg::SKEW_DEPTH];
    logic [LANES-1:0][PW:0]     wr_ptr;
    logic [PW:0]                rd_ptr;
    logic [LANES-1:0]           seen;
    logic [LANES-1:0]           wr_en;
    logic [LANES-1:0]           has_data;
    logic                       started;
    logic                       act_q;
    logic                       clear;
    logic                       rd_en;

    // any lane leaving HS ends the burst
    assign clear = ~&rxactivehs;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            wr_en[i]    = !clear && ((rxsynchs[i] && !seen[i]) || (seen[i] && rxvalidhs[i]));
            has_data[i] = (wr_ptr[i] != rd_ptr);
        end
    end

    // lockstep read as soon as the slowest lane has its sync byte stored
    assign rd_en = &has_data;

    always_ff @(posedge rxbyteclkhs or negedge rst_n) begin
        if (!rst_n) begin
            seen    <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            started <= 1'b0;
            act_q   <= 1'b0;
        end else begin
            act_q <= &rxactivehs;
            if (clear) begin
                seen    <= '0;
                wr_ptr  <= '0;
                rd_ptr  <= '0;
                started <= 1'b0;
            end else begin
                for (int i = 0; i < LANES; i++) begin
                    if (wr_en[i]) begin
                        seen[i]   <= 1'b1;
                        wr_ptr[i] <= wr_ptr[i] + 1'b1;
                    end
                end
                if (rd_en) begin
                    rd_ptr  <= rd_ptr + 1'b1;
                    started <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge rxbyteclkhs) begin
        for (int i = 0; i < LANES; i++) begin
            if (wr_en[i]) begin
                lane_buf[i][wr_ptr[i][PW-1:0]] <= rxdatahs[i*BW +: BW];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            aligned_data[i*BW +: BW] = lane_buf[i][rd_ptr[PW-1:0]];
        end
    end

    assign aligned_valid  = rd_en;
    assign aligned_sync   = rd_en && !started;
    assign aligned_active = act_q;

    // --------------------------------------------------------------------------
    // last written entry stays within MAX_SKEW of the read side
    // --------------------------------------------------------------------------
    for (genvar i = 0; i < LANES; i++) begin : g_skew_chk
        logic [PW:0] fill;
        assign fill = wr_ptr[i] - rd_ptr;
        assert property (@(posedge rxbyteclkhs) disable iff (!rst_n)
            fill <= mipi_rx_pkg::SKEW_DEPTH)
            else $error("lane %0d skew beyond buffer depth", i);
    end

endmodule

`default_nettype wire

/* verilog/mipi_rx_pkg.sv */
// --------------------------------------------------------------------------
// shared widths and constants for the CSI-2 receive lane merger
// referenced by scoped name from the RTL and the testbench
// --------------------------------------------------------------------------

`default_nettype none

package mipi_rx_pkg;

    localparam int BYTE_WIDTH = 8;
    // first and last flags carried next to each FIFO word
    localparam int FLAG_WIDTH = 2;
    localparam int MAX_SKEW   = 3;
    localparam int SKEW_DEPTH = MAX_SKEW + 1;

    // log2 of the lane count, for 1, 2 or 4 lanes
    function automatic int lane_size(input int lanes);
        return (lanes == 4) ? 2 : (lanes == 2) ? 1 : 0;
    endfunction

endpackage

`default_nettype wire

/* verilog/mipi_rx_width_conv.sv */
// --------------------------------------------------------------------------
// upsizer from lane words to the AXI4-Stream output word
// lowest byte first; a packet that ends mid-word is zero padded
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mipi_rx_width_conv #(
    parameter int LANES      = 2,
    parameter int TDATA_SIZE = 2
) (
    input  logic                                       rst_n,
    input  logic                                       aclk,
    input  logic [LANES*mipi_rx_pkg::BYTE_WIDTH-1:0]   s_data,
    input  logic                                       s_first,
    input  logic                                       s_last,
    input  logic                                       s_valid,
    output logic                                       s_ready,
    output logic [(8 << TDATA_SIZE)-1:0]               tdata,
    output logic                                       tuser,
    output logic                                       tlast,
    output logic                                       tvalid,
    input  logic                                       tready
);

    localparam int S_WIDTH = LANES * mipi_rx_pkg::BYTE_WIDTH;
    localparam int T_WIDTH = 8 << TDATA_SIZE;
    localparam int RATIO   = 1 << (TDATA_SIZE - mipi_rx_pkg::lane_size(LANES));
    localparam int CNT_W   = (RATIO > 1) ? $clog2(RATIO) : 1;

    logic [T_WIDTH-1:0] acc;
    logic [T_WIDTH-1:0] next_word;
    logic [CNT_W-1:0]   cnt;
    logic [CNT_W-1:0]   slot;
    logic               acc_first;
    logic               next_first;
    logic               accept;
    logic               done;

    assign s_ready = !tvalid || tready;
    assign accept  = s_valid && s_ready;

    always_comb begin
        slot       = s_first ? '0 : cnt;
        next_word  = s_first ? '0 : acc;
        next_word[slot*S_WIDTH +: S_WIDTH] = s_data;
        next_first = s_first || acc_first;
    end

    assign done = (slot == CNT_W'(RATIO - 1)) || s_last;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            acc_first <= 1'b0;
            tvalid    <= 1'b0;
            tuser     <= 1'b0;
            tlast     <= 1'b0;
        end else begin
            if (tready) begin
                tvalid <= 1'b0;
            end
            if (accept) begin
                if (done) begin
                    cnt       <= '0;
                    acc_first <= 1'b0;
                    tvalid    <= 1'b1;
                    tuser     <= next_first;
                    tlast     <= s_last;
                end else begin
                    cnt       <= CNT_W'(slot + 1'b1);
                    acc_first <= next_first;
                end
            end
        end
    end

    // cleared accumulator gives the padding
    always_ff @(posedge aclk) begin
        if (accept) begin
            if (done) begin
                tdata <= next_word;
                acc   <= '0;
            end else begin
                acc   <= next_word;
            end
        end
    end

    // upstream FIFO holds its word until it is taken
    assert property (@(posedge aclk) disable iff (!rst_n)
        (s_valid && !s_ready) |=> (s_valid && $stable({s_first, s_last, s_data})))
        else $error("input word changed while stalled");

endmodule

`default_nettype wire
